// File: Bender.yml
package:
  name: leaf_interface

sources:
  - common/leaf_pkg.sv
  - common/leaf_cfg_pkg.sv
  - rx/packet_decoder.sv
  - verilog/leaf_config.sv
  - stream/user_in_port.sv
  - stream/user_out_port.sv
  - verilog/leaf_interface.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/leaf_interface_tb.sv

// File: bench/leaf_model.svh
`ifndef LEAF_MODEL_SVH
`define LEAF_MODEL_SVH

// payloads still owed to the user kernel, oldest first
leaf_pkg::payload_t   expected_q[$];
// mirror of the configuration registers
leaf_cfg_pkg::route_t model_route;
leaf_pkg::leaf_t      model_self_leaf;
// address the output side should stamp on its next packet
leaf_pkg::addr_t      model_addr;

// config payload carries the port in the low bits and the leaf right above
function automatic leaf_pkg::payload_t config_payload(input leaf_pkg::leaf_t cfg_leaf,
                                                      input leaf_pkg::port_t cfg_port);
    leaf_pkg::payload_t payload;
    payload = '0;
    payload[leaf_pkg::PORT_BITS-1:0]                    = cfg_port;
    payload[leaf_pkg::PORT_BITS +: leaf_pkg::LEAF_BITS] = cfg_leaf;
    return payload;
endfunction

// packet for one accepted user word
// address moves on afterwards and wraps with its width
function automatic leaf_pkg::packet_t next_expected_packet(input leaf_pkg::payload_t word);
    leaf_pkg::packet_t pkt;
    pkt.valid   = 1'b1;
    pkt.leaf    = model_route.leaf;
    pkt.port    = model_route.port;
    pkt.addr    = model_addr;
    pkt.payload = word;
    model_addr  = model_addr + 1'b1;
    return pkt;
endfunction

// state right after reset
function automatic void model_clear();
    expected_q.delete();
    model_route     = '0;
    model_self_leaf = '0;
    model_addr      = '0;
endfunction

// ap_start rise: stream state goes, configuration stays
function automatic void model_restart();
    expected_q.delete();
    model_addr = '0;
endfunction

`endif

// File: bench/leaf_interface_tb.sv
module leaf_interface_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROUTE_WORDS  = 20;
    localparam int DATA_WORDS   = 30;
    localparam int FILTER_WORDS = 24;
    // rough cycle budget of each test
    localparam int RESET_LEN    = 10;
    localparam int ROUTE_LEN    = ROUTE_WORDS * 12;
    localparam int DATA_LEN     = DATA_WORDS * 16;
    localparam int FILTER_LEN   = FILTER_WORDS * 16;
    localparam int RESTART_LEN  = 150;
    localparam int TIMEOUT_CYCLES =
        4 * (RESET_LEN + ROUTE_LEN + DATA_LEN + FILTER_LEN + RESTART_LEN);

    logic               clk;
    logic               reset_ap_start_user;
    logic               ap_start;
    leaf_pkg::packet_t  din;
    leaf_pkg::packet_t  dout;
    logic               user_in_req;
    leaf_pkg::payload_t user_in_data;
    logic               user_in_ack;
    logic               user_out_req;
    leaf_pkg::payload_t user_out_data;
    logic               user_out_ack;

    integer seed         = 32'hb15ad5b0;
    string  current_test = "none";
    int     error_count  = 0;
    int     test_errors  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     cycle_count  = 0;
    int     dout_count   = 0;
    // stops the user responder from acking
    logic   hold_ack     = 1'b0;

    `include "leaf_model.svh"

    leaf_interface dut_i (
        .clk                 (clk),
        .reset_ap_start_user (reset_ap_start_user),
        .ap_start            (ap_start),
        .din                 (din),
        .dout                (dout),
        .user_in_req         (user_in_req),
        .user_in_data        (user_in_data),
        .user_in_ack         (user_in_ack),
        .user_out_req        (user_out_req),
        .user_out_data       (user_out_data),
        .user_out_ack        (user_out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // wide enough for a whole network packet
    task automatic check_value(input string what,
                               input logic [leaf_pkg::PACKET_BITS-1:0] expected,
                               input logic [leaf_pkg::PACKET_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h",
                     current_test, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", current_test, test_errors);
        end
    endtask

    // one network packet held valid for a single cycle with a random address field
    task automatic send_packet(input leaf_pkg::leaf_t dst_leaf, input leaf_pkg::port_t dst_port,
                               input leaf_pkg::payload_t word);
        din = '{valid:   1'b1,
                leaf:    dst_leaf,
                port:    dst_port,
                addr:    leaf_pkg::addr_t'($random(seed)),
                payload: word};
        next_cycle();
        din = '0;
    endtask

    // the leaf field of a config packet is ignored and so kept random
    task automatic send_config(input leaf_pkg::port_t cfg_kind, input leaf_pkg::leaf_t cfg_leaf,
                               input leaf_pkg::port_t cfg_port);
        send_packet(leaf_pkg::leaf_t'($random(seed)), cfg_kind, config_payload(cfg_leaf, cfg_port));
        repeat (3) next_cycle();
    endtask

    // user kernel side of the output handshake with dout checked as ack rises
    task automatic send_user_word(input leaf_pkg::payload_t word);
        leaf_pkg::packet_t expected;
        repeat ($unsigned($random(seed)) % 4) next_cycle();
        user_out_req  = 1'b1;
        user_out_data = word;
        while (user_out_ack !== 1'b1) next_cycle();
        expected = next_expected_packet(word);
        check_value("dout packet", expected, dout);
        user_out_req = 1'b0;
        while (user_out_ack !== 1'b0) next_cycle();
    endtask

    // data packet for this leaf is queued in the model first
    task automatic send_data_word();
        leaf_pkg::payload_t word;
        // the network cannot push back so the sender keeps to the queue depth
        while (expected_q.size() >= leaf_cfg_pkg::QUEUE_DEPTH) next_cycle();
        word = $random(seed);
        expected_q.push_back(word);
        send_packet(model_self_leaf, leaf_pkg::PORT_DATA, word);
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0) next_cycle();
        repeat (4) next_cycle();
    endtask

    task automatic take_delivery(input leaf_pkg::payload_t word);
        if (expected_q.size() == 0) begin
            $display("[%s] word 0x%0h reached the user although none was expected",
                     current_test, word);
            error_count++;
            test_errors++;
        end else begin
            check_value("user_in_data", expected_q.pop_front(), word);
        end
    endtask

    // user responder acks after 0 to 3 cycles and drops ack once req falls
    initial begin
        int delay;
        user_in_ack = 1'b0;
        forever begin
            next_cycle();
            if (user_in_req && !hold_ack) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) next_cycle();
                take_delivery(user_in_data);
                user_in_ack = 1'b1;
                while (user_in_req) next_cycle();
                user_in_ack = 1'b0;
            end
        end
    end

    // counts emitted packets to catch extra ones
    initial begin
        forever begin
            next_cycle();
            if (dout.valid === 1'b1) begin
                dout_count++;
            end
        end
    end

    // watchdog
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: test %s still running after %0d cycles", current_test, cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int                 start_count;
        int                 kind;
        leaf_pkg::leaf_t    other_leaf;
        model_clear();
        reset_ap_start_user = 1'b1;
        ap_start            = 1'b0;
        din                 = '0;
        user_out_req        = 1'b0;
        user_out_data       = '0;
        repeat (5) @(posedge clk);
        #1;
        reset_ap_start_user = 1'b0;

        start_test("reset");
        check_value("user_in_req", 1'b0, user_in_req);
        check_value("user_out_ack", 1'b0, user_out_ack);
        check_value("dout valid", 1'b0, dout.valid);
        finish_test();

        start_test("route_and_address");
        // nonzero leaf and port so the route differs from its reset value
        model_route = leaf_cfg_pkg::route_t'($random(seed) | 32'h11);
        send_config(leaf_pkg::PORT_ROUTE, model_route.leaf, model_route.port);
        start_count = dout_count;
        for (int i = 0; i < ROUTE_WORDS; i++) begin
            send_user_word($random(seed));
        end
        repeat (3) next_cycle();
        check_value("packet count", ROUTE_WORDS, dout_count - start_count);
        finish_test();

        start_test("data_delivery");
        // nonzero so the self leaf differs from its reset value
        model_self_leaf = leaf_pkg::leaf_t'($random(seed)) | 3'd1;
        send_config(leaf_pkg::PORT_SELF_LEAF, model_self_leaf, '0);
        for (int i = 0; i < DATA_WORDS; i++) begin
            send_data_word();
            repeat ($unsigned($random(seed)) % 3) next_cycle();
        end
        wait_drained();
        finish_test();

        start_test("filtering");
        for (int i = 0; i < FILTER_WORDS; i++) begin
            kind = $unsigned($random(seed)) % 3;
            if (kind == 0) begin
                send_data_word();
            end else if (kind == 1) begin
                // xor with a nonzero value always gives another leaf
                other_leaf = model_self_leaf ^ (leaf_pkg::leaf_t'($random(seed)) | 3'd1);
                send_packet(other_leaf, leaf_pkg::PORT_DATA, $random(seed));
            end else begin
                // ports 3 to 15 mean nothing to this leaf
                send_packet(model_self_leaf,
                            leaf_pkg::port_t'(3 + $unsigned($random(seed)) % 13),
                            $random(seed));
            end
            repeat ($unsigned($random(seed)) % 3) next_cycle();
        end
        wait_drained();
        finish_test();

        start_test("restart");
        hold_ack = 1'b1;
        // the model does not hold these words since they never reach the user
        for (int i = 0; i < 3; i++) begin
            send_packet(model_self_leaf, leaf_pkg::PORT_DATA, $random(seed));
        end
        while (!user_in_req) next_cycle();
        repeat (3) next_cycle();
        ap_start = 1'b1;
        repeat (2) next_cycle();
        ap_start = 1'b0;
        next_cycle();
        check_value("user_in_req after restart", 1'b0, user_in_req);
        model_restart();
        hold_ack = 1'b0;
        repeat (10) next_cycle();
        // address restarts at 0 and the route is kept
        for (int i = 0; i < 2; i++) begin
            send_user_word($random(seed));
        end
        for (int i = 0; i < 3; i++) begin
            send_data_word();
        end
        wait_drained();
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: common/leaf_cfg_pkg.sv
package leaf_cfg_pkg;

    // entries in the input data queue
    localparam int QUEUE_DEPTH = 4;

    // decoded config command
    typedef enum logic [1:0] {
        CFG_NONE,
        CFG_SELF_LEAF,
        CFG_ROUTE
    } cfg_op_e;

    // leaf is used by both opcodes, port only by CFG_ROUTE
    typedef struct packed {
        cfg_op_e         op;
        leaf_pkg::leaf_t leaf;
        leaf_pkg::port_t port;
    } cfg_cmd_t;

    // destination of packets built from user words
    typedef struct packed {
        leaf_pkg::leaf_t leaf;
        leaf_pkg::port_t port;
    } route_t;

    // four-phase req/ack state, shared by both user ports
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_RELEASE
    } hs_state_e;

endpackage

// File: common/leaf_pkg.sv
package leaf_pkg;

    // field widths of a network packet
    localparam int LEAF_BITS    = 3;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;
    localparam int PAYLOAD_BITS = 32;

    // valid bit + leaf + port + addr + payload
    localparam int PACKET_BITS = 1 + LEAF_BITS + PORT_BITS + ADDR_BITS + PAYLOAD_BITS;

    typedef logic [LEAF_BITS-1:0]    leaf_t;
    typedef logic [PORT_BITS-1:0]    port_t;
    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;

    // msb first, same order as on the network wires
    typedef struct packed {
        logic     valid;
        leaf_t    leaf;
        port_t    port;
        addr_t    addr;
        payload_t payload;
    } packet_t;

    // ports 0 and 1 carry configuration, port 2 carries user data
    // config payload layout: port in [PORT_BITS-1:0], leaf just above it
    localparam port_t PORT_SELF_LEAF = 4'd0;
    localparam port_t PORT_ROUTE     = 4'd1;
    localparam port_t PORT_DATA      = 4'd2;

endpackage

// File: leaf_interface.f
+incdir+bench
common/leaf_pkg.sv
common/leaf_cfg_pkg.sv
rx/packet_decoder.sv
verilog/leaf_config.sv
stream/user_in_port.sv
stream/user_out_port.sv
verilog/leaf_interface.sv
bench/leaf_interface_tb.sv

// File: rx/packet_decoder.sv
module packet_decoder (
    input  logic                   clk,
    input  logic                   reset_ap_start_user,
    input  leaf_pkg::packet_t      din,
    input  leaf_pkg::leaf_t        self_leaf,
    output leaf_cfg_pkg::cfg_cmd_t cmd,
    output logic                   data_valid,
    output leaf_pkg::payload_t     data_word
);

    leaf_cfg_pkg::cfg_op_e op_next;
    leaf_cfg_pkg::cfg_op_e op_q;
    leaf_pkg::leaf_t       cfg_leaf_q;
    leaf_pkg::port_t       cfg_port_q;
    logic                  data_hit;

    // config packets are taken for any leaf field
    always_comb begin
        op_next = leaf_cfg_pkg::CFG_NONE;
        if (din.valid) begin
            case (din.port)
                leaf_pkg::PORT_SELF_LEAF: op_next = leaf_cfg_pkg::CFG_SELF_LEAF;
                leaf_pkg::PORT_ROUTE:     op_next = leaf_cfg_pkg::CFG_ROUTE;
                default:                  op_next = leaf_cfg_pkg::CFG_NONE;
            endcase
        end
    end

    // data only for this leaf on the data port
    // everything else is silently dropped
    assign data_hit = din.valid
                   && (din.port == leaf_pkg::PORT_DATA)
                   && (din.leaf == self_leaf);

    // control flops
    always_ff @(posedge clk) begin
        if (reset_ap_start_user) begin
            op_q       <= leaf_cfg_pkg::CFG_NONE;
            data_valid <= 1'b0;
        end else begin
            op_q       <= op_next;
            data_valid <= data_hit;
        end
    end

    // payload fields, only meaningful alongside op_q or data_valid
    always_ff @(posedge clk) begin
        cfg_port_q <= din.payload[leaf_pkg::PORT_BITS-1:0];
        cfg_leaf_q <= din.payload[leaf_pkg::PORT_BITS +: leaf_pkg::LEAF_BITS];
        data_word  <= din.payload;
    end

    assign cmd = '{op: op_q, leaf: cfg_leaf_q, port: cfg_port_q};

endmodule

// File: stream/user_in_port.sv
module user_in_port (
    input  logic               clk,
    input  logic               reset_ap_start_user,
    input  logic               restart,
    input  logic               data_valid,
    input  leaf_pkg::payload_t data_word,
    output logic               user_in_req,
    output leaf_pkg::payload_t user_in_data,
    input  logic               user_in_ack
);

    leaf_pkg::payload_t queue_mem [leaf_cfg_pkg::QUEUE_DEPTH];

    // depth is a power of two, so pointers wrap by overflow
    logic [$clog2(leaf_cfg_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(leaf_cfg_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(leaf_cfg_pkg::QUEUE_DEPTH+1)-1:0] count;
    leaf_cfg_pkg::hs_state_e                        state;
    logic                                           full;
    logic                                           empty;
    logic                                           push;
    logic                                           pop;

    assign full  = (count == leaf_cfg_pkg::QUEUE_DEPTH);
    assign empty = (count == '0);
    assign push  = data_valid && !full;
    // head leaves the queue when a new handshake starts
    assign pop   = (state == leaf_cfg_pkg::HS_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= data_word;
        end
    end

    // queue bookkeeping, restart throws away whatever is still queued
    always_ff @(posedge clk) begin
        if (reset_ap_start_user || restart) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // four-phase sender
    // next word only goes out once ack has dropped again
    always_ff @(posedge clk) begin
        if (reset_ap_start_user || restart) begin
            state       <= leaf_cfg_pkg::HS_IDLE;
            user_in_req <= 1'b0;
        end else begin
            case (state)
                leaf_cfg_pkg::HS_IDLE: begin
                    if (!empty) begin
                        user_in_req <= 1'b1;
                        state       <= leaf_cfg_pkg::HS_REQ;
                    end
                end
                leaf_cfg_pkg::HS_REQ: begin
                    if (user_in_ack) begin
                        user_in_req <= 1'b0;
                        state       <= leaf_cfg_pkg::HS_RELEASE;
                    end
                end
                leaf_cfg_pkg::HS_RELEASE: begin
                    if (!user_in_ack) begin
                        state <= leaf_cfg_pkg::HS_IDLE;
                    end
                end
                default: begin
                    state <= leaf_cfg_pkg::HS_IDLE;
                end
            endcase
        end
    end

    // data is loaded together with the req rise and held after that
    always_ff @(posedge clk) begin
        if (pop) begin
            user_in_data <= queue_mem[rd_ptr];
        end
    end

    // network has no back-pressure, the sender has to respect QUEUE_DEPTH
    a_no_overflow : assert property (
        @(posedge clk) disable iff (reset_ap_start_user || restart)
        data_valid |-> !full
    );

    a_data_stable : assert property (
        @(posedge clk) disable iff (reset_ap_start_user || restart)
        $past(user_in_req) && user_in_req |-> $stable(user_in_data)
    );

endmodule

// File: stream/user_out_port.sv
module user_out_port (
    input  logic                 clk,
    input  logic                 reset_ap_start_user,
    input  logic                 restart,
    input  leaf_cfg_pkg::route_t route,
    input  logic                 user_out_req,
    input  leaf_pkg::payload_t   user_out_data,
    output logic                 user_out_ack,
    output leaf_pkg::packet_t    dout
);

    leaf_cfg_pkg::hs_state_e state;
    leaf_pkg::addr_t         addr;
    logic                    accept;
    logic                    out_valid;
    leaf_pkg::leaf_t         out_leaf;
    leaf_pkg::port_t         out_port;
    leaf_pkg::addr_t         out_addr;
    leaf_pkg::payload_t      out_payload;

    // a word is taken when req is seen high while idle
    assign accept = (state == leaf_cfg_pkg::HS_IDLE) && user_out_req;

    // four-phase receiver plus running address
    // address wraps at 2**ADDR_BITS by overflow
    always_ff @(posedge clk) begin
        if (reset_ap_start_user || restart) begin
            state        <= leaf_cfg_pkg::HS_IDLE;
            user_out_ack <= 1'b0;
            out_valid    <= 1'b0;
            addr         <= '0;
        end else begin
            out_valid <= accept;
            case (state)
                leaf_cfg_pkg::HS_IDLE: begin
                    if (user_out_req) begin
                        user_out_ack <= 1'b1;
                        addr         <= addr + 1'b1;
                        state        <= leaf_cfg_pkg::HS_REQ;
                    end
                end
                leaf_cfg_pkg::HS_REQ: begin
                    // wait for the user to drop req, then release ack
                    if (!user_out_req) begin
                        user_out_ack <= 1'b0;
                        state        <= leaf_cfg_pkg::HS_RELEASE;
                    end
                end
                leaf_cfg_pkg::HS_RELEASE: begin
                    state <= leaf_cfg_pkg::HS_IDLE;
                end
                default: begin
                    state <= leaf_cfg_pkg::HS_IDLE;
                end
            endcase
        end
    end

    // packet fields, captured with the accepted word
    always_ff @(posedge clk) begin
        if (accept) begin
            out_leaf    <= route.leaf;
            out_port    <= route.port;
            out_addr    <= addr;
            out_payload <= user_out_data;
        end
    end

    assign dout = '{valid:   out_valid,
                    leaf:    out_leaf,
                    port:    out_port,
                    addr:    out_addr,
                    payload: out_payload};

    // exactly one packet per handshake, in the cycle ack goes up
    a_one_packet : assert property (
        @(posedge clk) disable iff (reset_ap_start_user || restart)
        dout.valid |-> user_out_ack && !$past(user_out_ack)
    );

endmodule

// File: verilog/leaf_config.sv
module leaf_config (
    input  logic                   clk,
    input  logic                   reset_ap_start_user,
    input  leaf_cfg_pkg::cfg_cmd_t cmd,
    input  logic                   ap_start,
    output leaf_pkg::leaf_t        self_leaf,
    output leaf_cfg_pkg::route_t   route,
    output logic                   restart
);

    logic ap_start_q;

    // configuration registers
    // kept across restart, only reset clears them
    always_ff @(posedge clk) begin
        if (reset_ap_start_user) begin
            self_leaf <= '0;
            route     <= '0;
        end else begin
            case (cmd.op)
                leaf_cfg_pkg::CFG_SELF_LEAF: begin
                    self_leaf <= cmd.leaf;
                end
                leaf_cfg_pkg::CFG_ROUTE: begin
                    route.leaf <= cmd.leaf;
                    route.port <= cmd.port;
                end
                default: begin
                    // CFG_NONE, hold
                end
            endcase
        end
    end

    // ap_start edge detect
    // restart is high for one cycle right after the first high sample
    always_ff @(posedge clk) begin
        if (reset_ap_start_user) begin
            ap_start_q <= 1'b0;
            restart    <= 1'b0;
        end else begin
            ap_start_q <= ap_start;
            restart    <= ap_start && !ap_start_q;
        end
    end

    // decoder must only ever hand over a legal opcode
    a_cmd_op_legal : assert property (
        @(posedge clk) disable iff (reset_ap_start_user)
        cmd.op inside {leaf_cfg_pkg::CFG_NONE,
                       leaf_cfg_pkg::CFG_SELF_LEAF,
                       leaf_cfg_pkg::CFG_ROUTE}
    );

endmodule

// File: verilog/leaf_interface.sv
module leaf_interface (
    input  logic               clk,
    input  logic               reset_ap_start_user,
    input  logic               ap_start,
    input  leaf_pkg::packet_t  din,
    output leaf_pkg::packet_t  dout,
    output logic               user_in_req,
    output leaf_pkg::payload_t user_in_data,
    input  logic               user_in_ack,
    input  logic               user_out_req,
    input  leaf_pkg::payload_t user_out_data,
    output logic               user_out_ack
);

    leaf_cfg_pkg::cfg_cmd_t cmd;
    leaf_cfg_pkg::route_t   route;
    leaf_pkg::leaf_t        self_leaf;
    leaf_pkg::payload_t     data_word;
    logic                   data_valid;
    logic                   restart;

    // network side, splits config from data
    packet_decoder decoder_i (
        .clk                 (clk),
        .reset_ap_start_user (reset_ap_start_user),
        .din                 (din),
        .self_leaf           (self_leaf),
        .cmd                 (cmd),
        .data_valid          (data_valid),
        .data_word           (data_word)
    );

    leaf_config config_i (
        .clk                 (clk),
        .reset_ap_start_user (reset_ap_start_user),
        .cmd                 (cmd),
        .ap_start            (ap_start),
        .self_leaf           (self_leaf),
        .route               (route),
        .restart             (restart)
    );

    // toward the user kernel
    user_in_port in_port_i (
        .clk                 (clk),
        .reset_ap_start_user (reset_ap_start_user),
        .restart             (restart),
        .data_valid          (data_valid),
        .data_word           (data_word),
        .user_in_req         (user_in_req),
        .user_in_data        (user_in_data),
        .user_in_ack         (user_in_ack)
    );

    // from the user kernel back onto the network
    user_out_port out_port_i (
        .clk                 (clk),
        .reset_ap_start_user (reset_ap_start_user),
        .restart             (restart),
        .route               (route),
        .user_out_req        (user_out_req),
        .user_out_data       (user_out_data),
        .user_out_ack        (user_out_ack),
        .dout                (dout)
    );

endmodule
